//--- logic/vdma_config.svh
`ifndef VDMA_CONFIG_SVH
`define VDMA_CONFIG_SVH

// lane geometry of the vector processor.
`define VDMA_NUMLANES   4
`define VDMA_LANE_WIDTH 16
`define VDMA_LANE_AW    8

// main memory is byte addressed.
`define VDMA_BUS_AW     32

// one bus beat carries one word from every lane.
`define VDMA_BEAT_WIDTH (`VDMA_NUMLANES * `VDMA_LANE_WIDTH)
`define VDMA_BEAT_BYTES (`VDMA_BEAT_WIDTH / 8)

`endif

//--- logic/vdma_pkg.sv
`default_nettype none

`include "vdma_config.svh"

package vdma_pkg;

  // opcode field of the command word.
  typedef enum logic [1:0] {
    DMA_NOP   = 2'd0,
    DMA_LOAD  = 2'd1,
    DMA_STORE = 2'd2
  } dma_op_e;

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    LOAD_REQ   = 3'd1,
    READ_WAIT  = 3'd2,
    LOAD_DATA  = 3'd3,
    LANE_WRITE = 3'd4,
    STORE_REQ  = 3'd5,
    WRITE_WAIT = 3'd6,
    STORE_NEXT = 3'd7
  } dma_state_e;

  // decoded command as handed to the engine.
  typedef struct packed {
    dma_op_e                   op;
    logic [`VDMA_BUS_AW-1:0]   mem_base;   // byte address, beat aligned.
    logic [`VDMA_LANE_AW-1:0]  lane_base;
    logic [15:0]               len_bytes;  // always a whole number of beats.
  } dma_cmd_t;

  // request side of the main-memory data bus.
  typedef struct packed {
    logic [`VDMA_BUS_AW-1:0]      addr;
    logic                         en;
    logic                         wren;
    logic [`VDMA_BEAT_BYTES-1:0]  byteen;
    logic [`VDMA_BEAT_WIDTH-1:0]  wrdata;
  } dbus_req_t;

endpackage

`default_nettype wire

//--- logic/dma_cmd_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdma_config.svh"

module dma_cmd_decode (
  input  wire                 clk,
  input  wire                 resetn,
  input  wire                 cmd_valid,
  input  wire [31:0]          cmd_word,
  input  wire                 busy,
  output logic                start,
  output vdma_pkg::dma_cmd_t  cmd,
  output logic                nop_done,
  output logic                reject
);

  vdma_pkg::dma_op_e   op;
  logic [5:0]          beats;
  logic [15:0]         mem_index;
  vdma_pkg::dma_cmd_t  cmd_next;
  logic                engaged;
  logic                runnable;
  logic                accept;

  assign op        = vdma_pkg::dma_op_e'(cmd_word[31:30]);
  assign beats     = cmd_word[21:16];
  assign mem_index = cmd_word[15:0];

  // the length field counts beats, so the byte length is whole beats by construction.
  always_comb begin
    cmd_next.op        = op;
    cmd_next.lane_base = cmd_word[29:22];
    cmd_next.mem_base  = {{(`VDMA_BUS_AW-19){1'b0}}, mem_index, 3'b000};
    cmd_next.len_bytes = {7'd0, beats, 3'b000};
  end

  // the engine raises busy one cycle after start, so a pending start counts as busy too.
  assign engaged  = busy | start;
  assign runnable = ((op == vdma_pkg::DMA_LOAD) || (op == vdma_pkg::DMA_STORE)) &&
                    (beats != 6'd0);
  assign accept   = cmd_valid && !engaged;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      start    <= 1'b0;
      nop_done <= 1'b0;
      reject   <= 1'b0;
    end else begin
      start    <= accept && runnable;
      nop_done <= accept && !runnable;  // nop, unknown opcode or zero beats.
      reject   <= cmd_valid && engaged;
    end
  end

  // held for the whole transfer, since a rejected command never reaches it.
  always_ff @(posedge clk) begin
    if (accept && runnable) begin
      cmd <= cmd_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/dma_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdma_config.svh"

module dma_engine (
  input  wire                          clk,
  input  wire                          resetn,
  input  wire                          start,
  input  wire vdma_pkg::dma_cmd_t      cmd,
  input  wire [`VDMA_BEAT_WIDTH-1:0]   dbus_readdata,
  input  wire                          dbus_wait,
  input  wire                          dbus_data_valid,
  input  wire [`VDMA_BEAT_WIDTH-1:0]   lane_rddata,
  output vdma_pkg::dbus_req_t          dbus,
  output logic [`VDMA_LANE_AW-1:0]     lane_addr,
  output logic [`VDMA_NUMLANES-1:0]    lane_wren,
  output logic                         lane_rden,
  output logic [`VDMA_BEAT_WIDTH-1:0]  lane_wrdata,
  output logic                         busy,
  output logic [15:0]                  xfer_bytes
);

  localparam int BEAT_SHIFT = $clog2(`VDMA_BEAT_BYTES);

  vdma_pkg::dma_state_e           state;
  vdma_pkg::dma_state_e           state_next;
  logic [15:0]                    count;       // bytes moved so far.
  logic [15:0]                    count_step;
  logic                           last_beat;
  logic [`VDMA_LANE_AW-1:0]       beat_idx;
  logic [`VDMA_LANE_AW-1:0]       beat_idx_step;
  logic [`VDMA_BEAT_WIDTH-1:0]    beat_q;

  assign count_step    = count + 16'(`VDMA_BEAT_BYTES);
  assign last_beat     = (count_step == cmd.len_bytes);
  assign beat_idx      = count[BEAT_SHIFT +: `VDMA_LANE_AW];
  assign beat_idx_step = count_step[BEAT_SHIFT +: `VDMA_LANE_AW];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= vdma_pkg::IDLE;
      count <= 16'd0;
    end else begin
      state <= state_next;
      if ((state == vdma_pkg::IDLE) && start) begin
        count <= 16'd0;
      end else if ((state == vdma_pkg::LANE_WRITE) || (state == vdma_pkg::STORE_NEXT)) begin
        count <= count_step;
      end
    end
  end

  // read data normally arrives on the cycle the wait drops.
  // A memory that flags it one cycle later is still caught in LOAD_DATA.
  always_ff @(posedge clk) begin
    if (dbus_data_valid &&
        ((state == vdma_pkg::READ_WAIT) || (state == vdma_pkg::LOAD_DATA))) begin
      beat_q <= dbus_readdata;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      vdma_pkg::IDLE: begin
        if (start) begin
          state_next = (cmd.op == vdma_pkg::DMA_STORE) ? vdma_pkg::STORE_REQ :
                                                         vdma_pkg::LOAD_REQ;
        end
      end
      vdma_pkg::LOAD_REQ: state_next = vdma_pkg::READ_WAIT;
      vdma_pkg::READ_WAIT: begin
        if (!dbus_wait) begin
          state_next = vdma_pkg::LOAD_DATA;
        end
      end
      vdma_pkg::LOAD_DATA: state_next = vdma_pkg::LANE_WRITE;
      vdma_pkg::LANE_WRITE: begin
        state_next = last_beat ? vdma_pkg::IDLE : vdma_pkg::LOAD_REQ;
      end
      vdma_pkg::STORE_REQ: state_next = vdma_pkg::WRITE_WAIT;
      vdma_pkg::WRITE_WAIT: begin
        if (!dbus_wait) begin
          state_next = vdma_pkg::STORE_NEXT;
        end
      end
      vdma_pkg::STORE_NEXT: begin
        state_next = last_beat ? vdma_pkg::IDLE : vdma_pkg::STORE_REQ;
      end
      default: state_next = vdma_pkg::IDLE;
    endcase
  end

  // the scratchpad read has one cycle of latency.
  // Each store word is fetched in the cycle before its STORE_REQ.
  always_comb begin
    dbus.addr   = cmd.mem_base + {{(`VDMA_BUS_AW-16){1'b0}}, count};
    dbus.en     = 1'b0;
    dbus.wren   = 1'b0;
    dbus.byteen = '0;
    dbus.wrdata = lane_rddata;  // the scratchpad output holds until the next read.
    lane_addr   = cmd.lane_base + beat_idx;
    lane_wren   = '0;
    lane_rden   = 1'b0;
    case (state)
      vdma_pkg::IDLE: begin
        if (start && (cmd.op == vdma_pkg::DMA_STORE)) begin
          lane_rden = 1'b1;
          lane_addr = cmd.lane_base;
        end
      end
      vdma_pkg::LOAD_REQ: begin
        dbus.en     = 1'b1;
        dbus.byteen = '1;
      end
      vdma_pkg::LANE_WRITE: lane_wren = '1;
      vdma_pkg::STORE_REQ: begin
        dbus.en     = 1'b1;
        dbus.wren   = 1'b1;
        dbus.byteen = '1;
      end
      vdma_pkg::STORE_NEXT: begin
        if (!last_beat) begin
          lane_rden = 1'b1;
          lane_addr = cmd.lane_base + beat_idx_step;
        end
      end
      default: begin
      end
    endcase
  end

  assign lane_wrdata = beat_q;
  assign busy        = (state != vdma_pkg::IDLE);
  assign xfer_bytes  = count;  // equals the length once the engine is back in IDLE.

endmodule

`default_nettype wire

//--- logic/lane_scratchpad.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdma_config.svh"

module lane_scratchpad (
  input  wire                          clk,
  input  wire [`VDMA_LANE_AW-1:0]      addr,
  input  wire [`VDMA_NUMLANES-1:0]     wren,
  input  wire                          rden,
  input  wire [`VDMA_BEAT_WIDTH-1:0]   wrdata,
  output wire [`VDMA_BEAT_WIDTH-1:0]   rddata
);

  localparam int DEPTH = 1 << `VDMA_LANE_AW;
  localparam int LW    = `VDMA_LANE_WIDTH;

  // lane g owns bits [g*LW +: LW] of every beat.
  for (genvar g = 0; g < `VDMA_NUMLANES; g++) begin : g_lane
    logic [LW-1:0] mem [DEPTH];
    logic [LW-1:0] rd_q;

    always_ff @(posedge clk) begin
      if (wren[g]) begin
        mem[addr] <= wrdata[g*LW +: LW];
      end
      if (rden) begin
        rd_q <= mem[addr];  // holds its value while rden is low.
      end
    end

    assign rddata[g*LW +: LW] = rd_q;
  end

endmodule

`default_nettype wire

//--- logic/dma_status.sv
`timescale 1ns/1ns
`default_nettype none

module dma_status (
  input  wire         clk,
  input  wire         resetn,
  input  wire         busy,
  input  wire  [15:0] xfer_bytes,
  input  wire         nop_done,
  input  wire         reject,
  output logic        done,
  output logic [15:0] bytes_done,
  output logic        cmd_error
);

  logic busy_q;
  logic busy_fall;

  assign busy_fall = busy_q && !busy;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy_q     <= 1'b0;
      done       <= 1'b0;
      bytes_done <= 16'd0;
      cmd_error  <= 1'b0;
    end else begin
      busy_q <= busy;
      done   <= busy_fall || nop_done;  // the two never coincide.
      if (busy_fall) begin
        bytes_done <= xfer_bytes;
      end else if (nop_done) begin
        bytes_done <= 16'd0;
      end
      // Sticky until reset.
      if (reject) begin
        cmd_error <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/vdma_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdma_config.svh"

module vdma_top (
  input  wire                         clk,
  input  wire                         resetn,
  input  wire                         cmd_valid,
  input  wire [31:0]                  cmd_word,
  output logic                        busy,
  output logic                        done,
  output logic                        cmd_error,
  output logic [15:0]                 bytes_done,
  output vdma_pkg::dbus_req_t         dbus,
  input  wire [`VDMA_BEAT_WIDTH-1:0]  dbus_readdata,
  input  wire                         dbus_wait,
  input  wire                         dbus_data_valid
);

  logic                         start;
  vdma_pkg::dma_cmd_t           cmd;
  logic                         nop_done;
  logic                         reject;
  logic [15:0]                  xfer_bytes;
  logic [`VDMA_LANE_AW-1:0]     lane_addr;
  logic [`VDMA_NUMLANES-1:0]    lane_wren;
  logic                         lane_rden;
  logic [`VDMA_BEAT_WIDTH-1:0]  lane_wrdata;
  logic [`VDMA_BEAT_WIDTH-1:0]  lane_rddata;

  dma_cmd_decode decode0 (
    .clk       (clk),
    .resetn    (resetn),
    .cmd_valid (cmd_valid),
    .cmd_word  (cmd_word),
    .busy      (busy),
    .start     (start),
    .cmd       (cmd),
    .nop_done  (nop_done),
    .reject    (reject)
  );

  dma_engine engine0 (
    .clk             (clk),
    .resetn          (resetn),
    .start           (start),
    .cmd             (cmd),
    .dbus_readdata   (dbus_readdata),
    .dbus_wait       (dbus_wait),
    .dbus_data_valid (dbus_data_valid),
    .lane_rddata     (lane_rddata),
    .dbus            (dbus),
    .lane_addr       (lane_addr),
    .lane_wren       (lane_wren),
    .lane_rden       (lane_rden),
    .lane_wrdata     (lane_wrdata),
    .busy            (busy),
    .xfer_bytes      (xfer_bytes)
  );

  lane_scratchpad spad0 (
    .clk    (clk),
    .addr   (lane_addr),
    .wren   (lane_wren),
    .rden   (lane_rden),
    .wrdata (lane_wrdata),
    .rddata (lane_rddata)
  );

  dma_status status0 (
    .clk        (clk),
    .resetn     (resetn),
    .busy       (busy),
    .xfer_bytes (xfer_bytes),
    .nop_done   (nop_done),
    .reject     (reject),
    .done       (done),
    .bytes_done (bytes_done),
    .cmd_error  (cmd_error)
  );

endmodule

`default_nettype wire

//--- tests/dbus_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdma_config.svh"

module dbus_memory #(
  parameter int          MEM_BYTES = 4096,
  parameter logic [15:0] SEED      = 16'd84
) (
  input  wire                          clk,
  input  wire                          resetn,
  input  wire vdma_pkg::dbus_req_t     dbus,
  output logic [`VDMA_BEAT_WIDTH-1:0]  dbus_readdata,
  output logic                         dbus_wait,
  output logic                         dbus_data_valid
);

  logic [7:0]                   mem [MEM_BYTES];
  logic [31:0]                  wr_addr_log [256];
  logic [`VDMA_BEAT_WIDTH-1:0]  wr_data_log [256];
  logic [`VDMA_BEAT_BYTES-1:0]  wr_be_log [256];
  int                           wr_count;
  logic [15:0]                  lfsr;
  logic                         bit_lo;
  logic                         bit_hi;
  logic                         pending;
  logic                         pending_read;
  logic [31:0]                  pending_addr;
  int                           wait_left;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [`VDMA_BEAT_WIDTH-1:0] read_beat(input logic [31:0] a);
    logic [`VDMA_BEAT_WIDTH-1:0] beat;
    for (int i = 0; i < `VDMA_BEAT_BYTES; i++) begin
      beat[8*i +: 8] = mem[(a + 32'(i)) % MEM_BYTES];
    end
    return beat;
  endfunction

  initial begin
    // low address byte XOR 0x5A, with the upper bits folded in so pages differ.
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;
    end
    lfsr            = SEED;
    wr_count        = 0;
    pending         = 1'b0;
    dbus_wait       = 1'b0;
    dbus_data_valid = 1'b0;
    dbus_readdata   = '0;
  end

  // requests are taken mid-cycle, where the bus is stable.
  always @(negedge clk) begin
    if (resetn && dbus.en) begin
      bit_lo       = lfsr[0];
      lfsr         = lfsr_step(lfsr);
      bit_hi       = lfsr[0];
      lfsr         = lfsr_step(lfsr);
      wait_left    = int'({bit_hi, bit_lo});  // 0 to 3 wait cycles.
      pending      = 1'b1;
      pending_read = !dbus.wren;
      pending_addr = dbus.addr;
      if (dbus.wren) begin
        for (int i = 0; i < `VDMA_BEAT_BYTES; i++) begin
          if (dbus.byteen[i]) begin
            mem[(dbus.addr + 32'(i)) % MEM_BYTES] = dbus.wrdata[8*i +: 8];
          end
        end
        if (wr_count < 256) begin
          wr_addr_log[wr_count] = dbus.addr;
          wr_data_log[wr_count] = dbus.wrdata;
          wr_be_log[wr_count]   = dbus.byteen;
        end
        wr_count++;
      end
    end
  end

  always @(posedge clk) begin
    #1;
    dbus_data_valid = 1'b0;
    if (!resetn) begin
      pending   = 1'b0;
      dbus_wait = 1'b0;
    end else if (pending && (wait_left > 0)) begin
      dbus_wait = 1'b1;
      wait_left--;
    end else if (pending) begin
      dbus_wait = 1'b0;  // released; read data comes with the release.
      pending   = 1'b0;
      if (pending_read) begin
        dbus_data_valid = 1'b1;
        dbus_readdata   = read_beat(pending_addr);
      end
    end else begin
      dbus_wait = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_vdma.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdma_config.svh"

module tb_vdma;

  localparam int COLS      = 7;
  localparam int MAX_CMDS  = 32;
  localparam int MEM_BYTES = 4096;

  logic                         clk;
  logic                         resetn;
  logic                         cmd_valid;
  logic [31:0]                  cmd_word;
  logic                         busy;
  logic                         done;
  logic                         cmd_error;
  logic [15:0]                  bytes_done;
  vdma_pkg::dbus_req_t          dbus;
  logic [`VDMA_BEAT_WIDTH-1:0]  dbus_readdata;
  logic                         dbus_wait;
  logic                         dbus_data_valid;

  logic [15:0]                  stim [MAX_CMDS*COLS];
  logic [`VDMA_BEAT_WIDTH-1:0]  lane_model [256];
  int                           num_cmds;
  int                           total_beats;
  int                           req_count;
  int                           limit_cycles;
  logic                         limit_ready;

  vdma_top dut0 (
    .clk             (clk),
    .resetn          (resetn),
    .cmd_valid       (cmd_valid),
    .cmd_word        (cmd_word),
    .busy            (busy),
    .done            (done),
    .cmd_error       (cmd_error),
    .bytes_done      (bytes_done),
    .dbus            (dbus),
    .dbus_readdata   (dbus_readdata),
    .dbus_wait       (dbus_wait),
    .dbus_data_valid (dbus_data_valid)
  );

  dbus_memory #(.MEM_BYTES(MEM_BYTES)) mem0 (
    .clk             (clk),
    .resetn          (resetn),
    .dbus            (dbus),
    .dbus_readdata   (dbus_readdata),
    .dbus_wait       (dbus_wait),
    .dbus_data_valid (dbus_data_valid)
  );

  always #4 clk = ~clk;

  function automatic logic [`VDMA_BEAT_WIDTH-1:0] source_beat(input logic [31:0] a);
    logic [`VDMA_BEAT_WIDTH-1:0] beat;
    logic [31:0]                 b;
    for (int i = 0; i < `VDMA_BEAT_BYTES; i++) begin
      b = a + 32'(i);
      beat[8*i +: 8] = b[7:0] ^ 8'(b >> 8) ^ 8'h5A;
    end
    return beat;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_idle();
    check_value("busy", busy, 0);
    check_value("done", done, 0);
    check_value("cmd_error", cmd_error, 0);
    check_value("dbus.en", dbus.en, 0);
  endtask

  // a load issued during a transfer must be dropped by the DUT.
  task automatic send_reject_probe();
    int waited;
    waited = 0;
    while (busy !== 1'b1) begin
      @(negedge clk);
      waited++;
      assert (waited < 20) else fail_run("busy never rose after a transfer command");
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b1;
    cmd_word  = {2'd1, 8'hc0, 6'd1, 16'd0};
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    cmd_word  = '0;
  endtask

  task automatic run_command(input int c);
    logic [1:0]  op;
    logic [7:0]  lane;
    logic [5:0]  beats;
    logic [31:0] base;
    logic [7:0]  slot;
    int          exp_beats;
    int          req_start;
    int          wr_start;
    int          waited;
    int          e;
    op        = stim[c*COLS][1:0];
    lane      = stim[c*COLS+1][7:0];
    beats     = stim[c*COLS+2][5:0];
    base      = {13'd0, stim[c*COLS+3], 3'b000};
    exp_beats = int'(stim[c*COLS+4]);
    req_start = req_count;
    wr_start  = mem0.wr_count;
    @(posedge clk);
    #1;
    cmd_valid = 1'b1;
    cmd_word  = {op, lane, beats, stim[c*COLS+3]};
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    cmd_word  = '0;
    if (stim[c*COLS+6][0]) begin
      send_reject_probe();
    end
    waited = 0;
    while (done !== 1'b1) begin
      @(negedge clk);
      waited++;
      assert (waited < 200*exp_beats + 50) else begin
        fail_run($sformatf("command %0d never finished", c));
      end
    end
    check_value("bytes_done", bytes_done, exp_beats * 8);
    check_value("bus request count", req_count - req_start, exp_beats);
    check_value("cmd_error", cmd_error, stim[c*COLS+5][0]);
    check_value("busy", busy, 0);
    for (int k = 0; k < exp_beats; k++) begin
      slot = lane + 8'(k);
      if (op == vdma_pkg::DMA_LOAD) begin
        lane_model[slot] = source_beat(base + 32'(k*8));
      end else if (op == vdma_pkg::DMA_STORE) begin
        e = wr_start + k;
        check_value("store address", mem0.wr_addr_log[e], base + 32'(k*8));
        check_value("store data", mem0.wr_data_log[e], lane_model[slot]);
        check_value("store byteen", mem0.wr_be_log[e], 8'hff);
      end
    end
    check_value("write count", mem0.wr_count - wr_start,
                (op == vdma_pkg::DMA_STORE) ? exp_beats : 0);
    @(negedge clk);
    check_value("done", done, 0);  // a single-cycle pulse.
  endtask

  always @(negedge clk) begin
    if (resetn && dbus.en) begin
      req_count++;
      assert (!dbus_wait) else fail_run("a bus request was issued while wait was high");
      assert (dbus.addr <= MEM_BYTES - 8) else fail_run("bus address outside the memory model");
      check_value("dbus.byteen", dbus.byteen, 8'hff);
    end
  end

  initial begin
    wait (limit_ready === 1'b1);
    repeat (limit_cycles) @(posedge clk);
    fail_run("watchdog expired before the command list finished");
  end

  initial begin
    clk         = 1'b0;
    resetn      = 1'b0;
    cmd_valid   = 1'b0;
    cmd_word    = '0;
    req_count   = 0;
    limit_ready = 1'b0;
    $readmemh("tests/vdma_stim.txt", stim);
    num_cmds    = 0;
    total_beats = 0;
    while ((num_cmds < MAX_CMDS) && (stim[num_cmds*COLS] !== 16'hffff)) begin
      total_beats += int'(stim[num_cmds*COLS+4]);
      num_cmds++;
    end
    assert (num_cmds > 0) else fail_run("the stimulus file holds no commands");
    limit_cycles = 200*total_beats + 100*num_cmds + 200;
    limit_ready  = 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    #1;
    resetn = 1'b1;
    @(negedge clk);
    check_idle();
    for (int c = 0; c < num_cmds; c++) begin
      run_command(c);
    end
    @(negedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/vdma_stim.txt
// columns: opcode lane_base beats mem_word_index expected_beats expected_cmd_error reject_probe
// all values in hex; a line of ffff ends the list. load sources never overlap store targets.
0000 0000 0000 0000 0000 0000 0000
0001 0010 0004 0020 0004 0000 0000
0002 0010 0004 0100 0004 0000 0000
0001 0000 0000 0040 0000 0000 0000
0001 0040 0008 0050 0008 0000 0000
0002 0040 0008 0140 0008 0000 0000
0001 0080 0006 0070 0006 0001 0001
0002 0080 0006 0160 0006 0001 0000
0002 0000 0000 0000 0000 0001 0000
0001 00fe 0004 0090 0004 0001 0000
0002 00fe 0004 0180 0004 0001 0001
0000 0033 0005 0011 0000 0001 0000
0001 0020 0010 00a0 0010 0001 0000
0002 0020 0010 01a0 0010 0001 0000
ffff ffff ffff ffff ffff ffff ffff

//--- src.f
+incdir+logic
logic/vdma_pkg.sv
logic/dma_cmd_decode.sv
logic/dma_engine.sv
logic/lane_scratchpad.sv
logic/dma_status.sv
logic/vdma_top.sv
tests/dbus_memory.sv
tests/tb_vdma.sv

//--- Bender.yml
package:
  name: vdma

sources:
  - include_dirs:
      - logic
    files:
      - logic/vdma_pkg.sv
      - logic/dma_cmd_decode.sv
      - logic/dma_engine.sv
      - logic/lane_scratchpad.sv
      - logic/dma_status.sv
      - logic/vdma_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/dbus_memory.sv
      - tests/tb_vdma.sv
